// ==== lruReplTop.f ====
src/lruPkg.sv
src/lruDualPortRam.sv
src/lruInitCounter.sv
src/lruRefSequencer.sv
src/lruPseudo.sv
src/lruReplTop.sv
sim/lruReplTb_chk.sv
sim/lruReplTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the replacement-state store testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f lruReplTop.f --top-module lruReplTb -o lruReplSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/lruReplSim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All checks passed"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// ==== sim/lruInput.txt ====
# op set wayA wayB expVec expIdx, numeric columns in hex
# both sends wayA on port 0 and wayB on port 1, lookref1 pairs a lookup with wayB on port 1
# Fresh sets answer way 0
test 2 0 0 0 0
lookup 3 0 0 1 0
lookup 0 0 0 1 0
lookup f 0 0 1 0
# References on both ports to different sets
test 3 0 0 0 0
ref0 5 1 0 0 0
ref1 9 3 0 0 0
lookup 5 0 0 2 1
lookup 9 0 0 4 2
ref0 9 4 0 0 0
lookup 9 0 0 8 3
ref1 5 8 0 0 0
lookup 5 0 0 2 1
idle 0 0 0 0 0
# Filling the last free way clears the set
test 4 0 0 0 0
ref0 9 8 0 0 0
lookup 9 0 0 1 0
ref1 5 6 0 0 0
lookup 5 0 0 1 0
ref0 9 2 0 0 0
lookup 9 0 0 1 0
# A port 1 reference beside a lookup is dropped
test 5 0 0 0 0
ref0 2 1 0 0 0
lookup 2 0 0 2 1
lookref1 2 0 2 2 1
lookup 2 0 0 2 1
lookref1 2 0 e 2 1
lookup 2 0 0 2 1
idle 0 0 0 0 0
# Same-set writes from both ports keep only port 0
test 6 0 0 0 0
lookup 7 0 0 1 0
both 7 1 2 0 0
lookup 7 0 0 2 1
both 7 4 2 0 0
lookup 7 0 0 2 1
ref1 7 2 0 0 0
lookup 7 0 0 8 3

// ==== sim/lruReplTb.sv ====
// Testbench for the replacement-state store, with the rdy sweep check and
// file-driven references and lookups against expected answers
module lruReplTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NEntries  = 16;
    localparam int IdxW      = $clog2(NEntries);
    localparam int ClkPeriod = 40;

    typedef logic [IdxW-1:0] setIdxT;

    logic           clk;
    logic           resetb;
    setIdxT         lookupIdx;
    logic           lookupEn;
    lruPkg::wayVecT lookupVecRsp;
    lruPkg::wayIdxT lookupRsp;
    setIdxT         refIdx0;
    lruPkg::wayVecT refWayVec0;
    logic           refEn0;
    setIdxT         refIdx1;
    lruPkg::wayVecT refWayVec1;
    logic           refEn1;
    logic           rdy;

    // Stimulus table, one entry per command line of the data file
    string opQ[$];
    int    setQ[$];
    int    wayAQ[$];
    int    wayBQ[$];
    int    expVecQ[$];
    int    expIdxQ[$];

    int    lineCount;
    int    watchCycles;
    int    checkCount;
    int    errCount;
    int    testChecks;
    int    testErrs;
    int    curTest;
    logic  loadOk;

    lruReplTop #(.NEntries(NEntries)) dut0 (
        .clk          (clk),
        .resetb       (resetb),
        .lookupIdx    (lookupIdx),
        .lookupEn     (lookupEn),
        .lookupVecRsp (lookupVecRsp),
        .lookupRsp    (lookupRsp),
        .refIdx0      (refIdx0),
        .refWayVec0   (refWayVec0),
        .refEn0       (refEn0),
        .refIdx1      (refIdx1),
        .refWayVec1   (refWayVec1),
        .refEn1       (refEn1),
        .rdy          (rdy)
    );

    initial clk = 1'b0;
    always #(ClkPeriod / 2) clk = ~clk;

    // ============================================================
    // Stimulus file
    // ============================================================

    // Columns are op, set, wayA, wayB, expVec, expIdx, numbers in hex
    task automatic loadStimulus(output logic ok);
        int    fd;
        int    n;
        string line;
        string op;
        int    s;
        int    a;
        int    b;
        int    v;
        int    x;
        ok        = 1'b1;
        lineCount = 0;
        fd        = $fopen("sim/lruInput.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open stimulus file sim/lruInput.txt");
            ok = 1'b0;
        end
        else
        begin
            while (!$feof(fd))
            begin
                n = $fgets(line, fd);
                if (n > 0)
                begin
                    lineCount++;
                    // Comment lines start with a hash, blank lines hold only the newline
                    if (line.len() > 1 && line.getc(0) != "#")
                    begin
                        if ($sscanf(line, "%s %h %h %h %h %h", op, s, a, b, v, x) == 6)
                        begin
                            opQ.push_back(op);
                            setQ.push_back(s);
                            wayAQ.push_back(a);
                            wayBQ.push_back(b);
                            expVecQ.push_back(v);
                            expIdxQ.push_back(x);
                        end
                        else
                        begin
                            $display("malformed stimulus at line %0d", lineCount);
                            ok = 1'b0;
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ============================================================
    // Compare tasks
    // ============================================================

    task automatic checkVec(input string sigName, input lruPkg::wayVecT got,
                            input lruPkg::wayVecT expVal);
        checkCount++;
        testChecks++;
        if (got !== expVal)
        begin
            errCount++;
            testErrs++;
            $display("FAIL %s exp 0x%h got 0x%h", sigName, expVal, got);
        end
    endtask

    task automatic checkIdx(input string sigName, input lruPkg::wayIdxT got,
                            input lruPkg::wayIdxT expVal);
        checkCount++;
        testChecks++;
        if (got !== expVal)
        begin
            errCount++;
            testErrs++;
            $display("FAIL %s exp 0x%h got 0x%h", sigName, expVal, got);
        end
    endtask

    task automatic checkRdy(input logic got, input logic expVal);
        checkCount++;
        testChecks++;
        if (got !== expVal)
        begin
            errCount++;
            testErrs++;
            $display("FAIL rdy exp 0x%h got 0x%h", expVal, got);
        end
    endtask

    // Prints the result line of the test that just ended
    task automatic closeTest();
        if (curTest != 0)
        begin
            $display("test %0d done: %0d checks, %0d errors", curTest, testChecks, testErrs);
        end
        testChecks = 0;
        testErrs   = 0;
    endtask

    // ============================================================
    // Drivers, all applied on the falling edge
    // ============================================================

    task automatic clearInputs();
        lookupEn   = 1'b0;
        lookupIdx  = '0;
        refEn0     = 1'b0;
        refIdx0    = '0;
        refWayVec0 = '0;
        refEn1     = 1'b0;
        refIdx1    = '0;
        refWayVec1 = '0;
    endtask

    // Commands that start a write need one idle cycle afterwards
    function automatic bit hasReference(input string op);
        return op == "ref0" || op == "ref1" || op == "both" || op == "lookref1";
    endfunction

    task automatic applyCmd(input int i);
        string op;
        op = opQ[i];
        if (op == "ref0" || op == "both")
        begin
            refEn0     = 1'b1;
            refIdx0    = setIdxT'(setQ[i]);
            refWayVec0 = lruPkg::wayVecT'(wayAQ[i]);
        end
        if (op == "ref1")
        begin
            refEn1     = 1'b1;
            refIdx1    = setIdxT'(setQ[i]);
            refWayVec1 = lruPkg::wayVecT'(wayAQ[i]);
        end
        // Port 1 side of a paired command carries wayB
        if (op == "both" || op == "lookref1")
        begin
            refEn1     = 1'b1;
            refIdx1    = setIdxT'(setQ[i]);
            refWayVec1 = lruPkg::wayVecT'(wayBQ[i]);
        end
        if (op == "lookup" || op == "lookref1")
        begin
            lookupEn  = 1'b1;
            lookupIdx = setIdxT'(setQ[i]);
        end
        if (!hasReference(op) && op != "lookup" && op != "idle")
        begin
            errCount++;
            $display("unknown stimulus command %s", op);
        end
    endtask

    // rdy must stay low until exactly NEntries edges after reset release
    task automatic runRdyTest();
        curTest = 1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        checkRdy(rdy, 1'b0);
        resetb = 1'b1;
        for (int e = 1; e <= NEntries; e++)
        begin
            @(posedge clk);
            @(negedge clk);
            checkRdy(rdy, e >= NEntries);
        end
    endtask

    task automatic runCmds();
        for (int i = 0; i < opQ.size(); i++)
        begin
            if (opQ[i] == "test")
            begin
                closeTest();
                curTest = setQ[i];
            end
            else
            begin
                applyCmd(i);
                @(posedge clk);
                @(negedge clk);
                clearInputs();
                // The answer comes from the registered port 1 read and holds until the next edge
                if (opQ[i] == "lookup" || opQ[i] == "lookref1")
                begin
                    checkVec("lookupVecRsp", lookupVecRsp, lruPkg::wayVecT'(expVecQ[i]));
                    // The index means nothing when no way is free
                    if (expVecQ[i] != 0)
                    begin
                        checkIdx("lookupRsp", lookupRsp, lruPkg::wayIdxT'(expIdxQ[i]));
                    end
                end
                if (hasReference(opQ[i]))
                begin
                    @(posedge clk);
                    @(negedge clk);
                end
            end
        end
    endtask

    // ============================================================
    // Main sequence and watchdog
    // ============================================================

    initial
    begin
        resetb     = 1'b0;
        checkCount = 0;
        errCount   = 0;
        testChecks = 0;
        testErrs   = 0;
        curTest    = 0;
        clearInputs();
        loadStimulus(loadOk);
        if (!loadOk)
        begin
            $display("Checks failed");
            $finish;
        end
        else
        begin
            watchCycles = lineCount + NEntries + 20;
            runRdyTest();
            runCmds();
            closeTest();
            $display("total: %0d checks, %0d errors", checkCount, errCount);
            if (errCount == 0)
            begin
                $display("All checks passed");
            end
            else
            begin
                $display("Checks failed");
            end
            $finish;
        end
    end

    // Limit scales with the length of the stimulus file and the init sweep
    initial
    begin
        wait (watchCycles > 0);
        #(watchCycles * ClkPeriod);
        $display("timeout after %0d cycles, the run did not finish", watchCycles);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== sim/lruReplTb_chk.sv ====
// Bound assertions on the pseudo-LRU block covering one-hot lookup answers
// and quiet ports and sequencers during the init sweep
module lruReplTb_chk
(
    input logic           clk,
    input logic           resetb,
    input logic           initDone,
    input logic           wen1,
    input logic           busy0,
    input logic           busy1,
    input lruPkg::wayVecT lookupVecRsp
);
    timeunit 1ns;
    timeprecision 1ps;

    // The encoder answers with at most one way
    lookupOneHot: assert property (@(posedge clk) disable iff (!resetb)
        $onehot0(lookupVecRsp))
        else $error("lookup answer is neither zero nor one-hot");

    // Before the sweep ends only the init write on port 0 may happen
    // Port 1 therefore never writes in that time
    initWriteOnly: assert property (@(posedge clk) disable iff (!resetb)
        !initDone |-> !wen1)
        else $error("port 1 write before initDone");

    // No reference can be captured while the sweep runs
    seqIdleInit: assert property (@(posedge clk) disable iff (!resetb)
        !initDone |-> (!busy0 && !busy1))
        else $error("reference sequencer busy before initDone");

endmodule

bind lruPseudo lruReplTb_chk chk0 (
    .clk          (clk),
    .resetb       (resetb),
    .initDone     (initDone),
    .wen1         (wen1),
    .busy0        (busy0),
    .busy1        (busy1),
    .lookupVecRsp (lookupVecRsp)
);

// ==== src/lruDualPortRam.sv ====
// Two-port synchronous RAM holding one pseudo-LRU way vector per set,
// with one-cycle read latency on each port
module lruDualPortRam
#(
    parameter int NEntries = 16
)
(
    input  logic                        clk,

    // Port 0
    input  logic [$clog2(NEntries)-1:0] addr0,
    input  logic                        wen0,
    input  lruPkg::wayVecT              wdata0,
    output lruPkg::wayVecT              rdata0,

    // Port 1
    input  logic [$clog2(NEntries)-1:0] addr1,
    input  logic                        wen1,
    input  lruPkg::wayVecT              wdata1,
    output lruPkg::wayVecT              rdata1
);

    // Storage array, one way vector per set
    lruPkg::wayVecT mem [NEntries];

    // Both ports share a single clock
    // The read word is captured at the same edge as any write, so a read of
    // a word being written in that cycle still returns the old contents
    always_ff @(posedge clk)
    begin
        rdata0 <= mem[addr0];
        rdata1 <= mem[addr1];

        // Port 1 is written first so that port 0 wins if both ever hit the
        // same word, though the pseudo-LRU block already prevents that
        if (wen1)
        begin
            mem[addr1] <= wdata1;
        end
        if (wen0)
        begin
            mem[addr0] <= wdata0;
        end
    end

endmodule

// ==== src/lruInitCounter.sv ====
// Post-reset initialization sweep over all set indices
module lruInitCounter
#(
    parameter int NEntries = 16
)
(
    input  logic                        clk,
    input  logic                        resetb,

    // Set currently being cleared by the sweep
    output logic [$clog2(NEntries)-1:0] initIdx,
    // High once every set has been cleared, and held from then on
    output logic                        initDone
);

    localparam int IdxW = $clog2(NEntries);

    // One bit wider than the set index
    // Its top bit sets exactly after NEntries increments
    logic [IdxW:0] sweepCnt;

    assign initIdx  = sweepCnt[IdxW-1:0];
    assign initDone = sweepCnt[IdxW];

    // Count one set per clock until the top bit rises, then freeze
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            sweepCnt <= '0;
        end
        else if (!initDone)
        begin
            sweepCnt <= sweepCnt + 1'b1;
        end
    end

endmodule

// ==== src/lruPkg.sv ====
// Shared way count, way vector and way index types, and the reference
// sequencer state encoding for the pseudo-LRU store
package lruPkg;

    // ============================================================
    // Way geometry
    // ============================================================

    // Number of ways in every cache set
    // The way vector and way index types below are sized from it
    localparam int NWays = 4;

    // One bit per way
    // Used for the pseudo-LRU state, reference masks and one-hot answers
    typedef logic [NWays-1:0] wayVecT;

    // Binary way number, as returned by the lookup encoder
    typedef logic [$clog2(NWays)-1:0] wayIdxT;

    // ============================================================
    // Reference sequencer states
    // ============================================================

    // A reference is first captured while idle, then written back
    // during the single cycle spent in refWrite
    typedef enum logic
    {
        refIdle,
        refWrite
    } refStateT;

endpackage

// ==== src/lruPseudo.sv ====
// Pseudo-LRU block with port arbitration, OR-and-clear update rule and
// the first-free-way lookup encoder
module lruPseudo
#(
    parameter int NEntries = 16
)
(
    input  logic                        clk,
    input  logic                        resetb,

    // Init sweep from the init counter
    input  logic [$clog2(NEntries)-1:0] initIdx,
    input  logic                        initDone,

    // Lookup port, answered one cycle after lookupEn
    input  logic [$clog2(NEntries)-1:0] lookupIdx,
    input  logic                        lookupEn,
    output lruPkg::wayVecT              lookupVecRsp,
    output lruPkg::wayIdxT              lookupRsp,

    // Reference ports, best effort
    input  logic [$clog2(NEntries)-1:0] refIdx0,
    input  logic [$clog2(NEntries)-1:0] refIdx1,
    input  lruPkg::wayVecT              refWayVec0,
    input  lruPkg::wayVecT              refWayVec1,
    input  logic                        refEn0,
    input  logic                        refEn1
);

    localparam int IdxW = $clog2(NEntries);

    typedef logic [IdxW-1:0] setIdxT;

    // OR the referenced ways into the stored vector
    // When every way ends up marked, the whole vector starts over at zero
    function automatic lruPkg::wayVecT orClear(input lruPkg::wayVecT cur,
                                               input lruPkg::wayVecT refWay);
        lruPkg::wayVecT merged;
        merged = cur | refWay;
        return (&merged) ? '0 : merged;
    endfunction

    setIdxT         addr0;
    setIdxT         addr1;
    logic           wen0;
    logic           wen1;
    lruPkg::wayVecT wdata0;
    lruPkg::wayVecT wdata1;
    lruPkg::wayVecT rdata0;
    lruPkg::wayVecT rdata1;

    logic           accept0;
    logic           accept1;
    logic           busy0;
    logic           busy1;
    setIdxT         heldIdx0;
    setIdxT         heldIdx1;
    lruPkg::wayVecT heldWay0;
    lruPkg::wayVecT heldWay1;

    lruDualPortRam #(.NEntries(NEntries)) ram0 (
        .clk    (clk),
        .addr0  (addr0),
        .wen0   (wen0),
        .wdata0 (wdata0),
        .rdata0 (rdata0),
        .addr1  (addr1),
        .wen1   (wen1),
        .wdata1 (wdata1),
        .rdata1 (rdata1)
    );

    // ============================================================
    // Port 0 serves the init sweep and reference port 0
    // ============================================================

    // References are only taken once the sweep has finished
    assign accept0 = refEn0 && initDone;

    lruRefSequencer #(.NEntries(NEntries)) seq0 (
        .clk       (clk),
        .resetb    (resetb),
        .accept    (accept0),
        .refIdx    (refIdx0),
        .refWayVec (refWayVec0),
        .busy      (busy0),
        .heldIdx   (heldIdx0),
        .heldWay   (heldWay0)
    );

    // Sweep writes every cycle until done, otherwise write in refWrite
    assign wen0 = busy0 || !initDone;

    always_comb
    begin
        if (!initDone)
        begin
            addr0  = initIdx;
            wdata0 = '0;
        end
        else if (busy0)
        begin
            addr0  = heldIdx0;
            wdata0 = orClear(rdata0, heldWay0);
        end
        else
        begin
            // Idle, so start reading the set of any incoming reference
            addr0  = refIdx0;
            wdata0 = '0;
        end
    end

    // ============================================================
    // Port 1 serves lookups first, reference port 1 second
    // ============================================================

    // A port 1 reference colliding with a lookup is dropped
    assign accept1 = refEn1 && !lookupEn && initDone;

    lruRefSequencer #(.NEntries(NEntries)) seq1 (
        .clk       (clk),
        .resetb    (resetb),
        .accept    (accept1),
        .refIdx    (refIdx1),
        .refWayVec (refWayVec1),
        .busy      (busy1),
        .heldIdx   (heldIdx1),
        .heldWay   (heldWay1)
    );

    // The write loses to a lookup, and to a port 0 write of the same set
    assign wen1 = busy1 && !lookupEn && !(wen0 && (addr0 == addr1));

    always_comb
    begin
        if (lookupEn)
        begin
            addr1  = lookupIdx;
            wdata1 = '0;
        end
        else if (busy1)
        begin
            addr1  = heldIdx1;
            wdata1 = orClear(rdata1, heldWay1);
        end
        else
        begin
            addr1  = refIdx1;
            wdata1 = '0;
        end
    end

    // Lookup encoder picks the lowest-numbered way whose bit is clear
    // An all-ones vector never reaches storage, but gives a zero answer
    always_comb
    begin
        lookupVecRsp = '0;
        lookupRsp    = '0;
        for (int w = lruPkg::NWays - 1; w >= 0; w--)
        begin
            if (!rdata1[w])
            begin
                lookupVecRsp    = '0;
                lookupVecRsp[w] = 1'b1;
                lookupRsp       = lruPkg::wayIdxT'(w);
            end
        end
    end

endmodule

// ==== src/lruRefSequencer.sv ====
// Two-state reference sequencer that captures one reference and holds it
// through the cycle in which it is written back
module lruRefSequencer
#(
    parameter int NEntries = 16
)
(
    input  logic                        clk,
    input  logic                        resetb,

    // Qualified request from the pseudo-LRU block
    input  logic                        accept,
    input  logic [$clog2(NEntries)-1:0] refIdx,
    input  lruPkg::wayVecT              refWayVec,

    // High during the write cycle, when new references are ignored
    output logic                        busy,
    output logic [$clog2(NEntries)-1:0] heldIdx,
    output lruPkg::wayVecT              heldWay
);

    localparam int IdxW = $clog2(NEntries);

    typedef logic [IdxW-1:0] setIdxT;

    lruPkg::refStateT state;
    setIdxT           idxReg;
    lruPkg::wayVecT   wayReg;
    logic             capture;

    // A reference is only taken while idle
    assign capture = (state == lruPkg::refIdle) && accept;

    assign busy    = (state == lruPkg::refWrite);
    assign heldIdx = idxReg;
    assign heldWay = wayReg;

    // ============================================================
    // State machine
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            state <= lruPkg::refIdle;
        end
        else
        begin
            case (state)
                lruPkg::refIdle:
                begin
                    if (accept)
                    begin
                        state <= lruPkg::refWrite;
                    end
                end
                // The write always completes in one cycle
                lruPkg::refWrite: state <= lruPkg::refIdle;
                default:          state <= lruPkg::refIdle;
            endcase
        end
    end

    // Held reference, loaded when the machine leaves idle
    always_ff @(posedge clk)
    begin
        if (capture)
        begin
            idxReg <= refIdx;
            wayReg <= refWayVec;
        end
    end

endmodule

// ==== src/lruReplTop.sv ====
// Top level of the replacement-state store, joining the init counter
// and the pseudo-LRU block
module lruReplTop
#(
    parameter int NEntries = 16
)
(
    input  logic                        clk,
    input  logic                        resetb,

    // Lookup port
    input  logic [$clog2(NEntries)-1:0] lookupIdx,
    input  logic                        lookupEn,
    output lruPkg::wayVecT              lookupVecRsp,
    output lruPkg::wayIdxT              lookupRsp,

    // Reference port 0
    input  logic [$clog2(NEntries)-1:0] refIdx0,
    input  lruPkg::wayVecT              refWayVec0,
    input  logic                        refEn0,

    // Reference port 1
    input  logic [$clog2(NEntries)-1:0] refIdx1,
    input  lruPkg::wayVecT              refWayVec1,
    input  logic                        refEn1,

    // Level, high once the init sweep has cleared every set
    output logic                        rdy
);

    localparam int IdxW = $clog2(NEntries);

    logic [IdxW-1:0] initIdx;
    logic            initDone;

    assign rdy = initDone;

    lruInitCounter #(.NEntries(NEntries)) init0 (
        .clk      (clk),
        .resetb   (resetb),
        .initIdx  (initIdx),
        .initDone (initDone)
    );

    lruPseudo #(.NEntries(NEntries)) lru0 (
        .clk          (clk),
        .resetb       (resetb),
        .initIdx      (initIdx),
        .initDone     (initDone),
        .lookupIdx    (lookupIdx),
        .lookupEn     (lookupEn),
        .lookupVecRsp (lookupVecRsp),
        .lookupRsp    (lookupRsp),
        .refIdx0      (refIdx0),
        .refIdx1      (refIdx1),
        .refWayVec0   (refWayVec0),
        .refWayVec1   (refWayVec1),
        .refEn0       (refEn0),
        .refEn1       (refEn1)
    );

endmodule
